// File: Makefile
TOOL     = verilator
FLAGS    = --binary --timing --assert
TOP      = tb_comm_controller
FILELIST = vlog.f
OBJDIR   = obj_dir

.PHONY: all lint sim clean

all: sim

lint:
	$(TOOL) --lint-only --timing --top-module $(TOP) -f $(FILELIST)

$(OBJDIR)/V$(TOP): $(FILELIST)
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJDIR)

sim: $(OBJDIR)/V$(TOP)
	./$(OBJDIR)/V$(TOP)

clean:
	rm -rf $(OBJDIR)

// File: testbench/tb_comm_controller.sv
`timescale 1ns/1ps

module tb_comm_controller import comm_proto_pkg::*, mem_bus_pkg::*; ();

	logic              clock_i;
	logic              resetn_i;
	logic              tx_full_i;
	logic              rx_empty_i;
	logic [WORD_W-1:0] rx_data_i;
	logic              rx_read_o;
	logic              tx_write_o;
	logic [WORD_W-1:0] tx_data_o;
	logic              ready_i;
	logic              done_i;
	logic [DATA_W-1:0] data_i;
	logic [DEV_W-1:0]  reqdev_o;
	logic              req_o;
	logic              rw_o;
	logic [ADDR_W-1:0] add_o;
	logic [DATA_W-1:0] data_o;
	logic              clear_o;
	logic              exception_o;

	// host fifo contents, expected transmit words, expected config requests
	logic [WORD_W-1:0] rx_q[$];
	logic [WORD_W-1:0] exp_q[$];
	logic [DEV_W-1:0]  cfg_dev_q[$];
	logic [1:0]        cfg_val_q[$];

	// bus memory and the shadow copy used for expected read data
	logic [DATA_W-1:0] mem [logic [ADDR_W-1:0]];
	logic [DATA_W-1:0] ref_mem [logic [ADDR_W-1:0]];

	int unsigned       lcg_state = 30;
	bit                stress = 1'b0;
	bit                err_mode = 1'b0;
	int                done_wait = 0;
	logic              pend_rw;
	logic [ADDR_W-1:0] pend_addr;

	comm_controller UUT (.*);

	// helpers
	// --------------------------------------------------
	function automatic int unsigned lcg_next();
		lcg_state = lcg_state * 32'd1103515245 + 32'd12345;
		return lcg_state >> 16;
	endfunction

	// fill pattern of memory that was never written
	function automatic logic [DATA_W-1:0] unwritten_value(logic [ADDR_W-1:0] addr);
		return {2'b00, addr} ^ 32'h5A5A_0000;
	endfunction

	// reference for a read response word
	function automatic logic [DATA_W-1:0] ref_read(logic [ADDR_W-1:0] addr);
		return ref_mem.exists(addr) ? ref_mem[addr] : unwritten_value(addr);
	endfunction

	task automatic report_mismatch(input string msg);
		$display("FAIL at %0t: %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "value check failed");
	endtask

	task automatic report_stall(input string msg);
		$display("timeout at %0t while waiting for %s", $time, msg);
		$display("Some tests failed");
		$fatal(1, "wait timed out");
	endtask

	// wait until the host has consumed all words and all answers came back
	task automatic wait_idle(input string what);
		int n;
		for (n = 0; n < 2000 && (exp_q.size() != 0 || rx_q.size() != 0); n++) begin
			@(negedge clock_i);
		end
		if (exp_q.size() != 0 || rx_q.size() != 0) begin
			report_stall(what);
		end
	endtask

	// kind 0 read, 1 write, 2 device config
	task automatic run_command(input int kind, input logic [2:0] dev, input logic [1:0] value,
	                           input bit counted, input logic [11:0] count,
	                           input logic [ADDR_W-1:0] addr);
		logic [11:0]       flags;
		logic [WORD_W-1:0] cmd;
		logic [WORD_W-1:0] wdata[$];
		logic [WORD_W-1:0] d;
		logic [ADDR_W-1:0] a;
		int                n;
		int                i;
		// block and cache bits are set and must be ignored
		flags = 12'h0A0;
		n = (counted && count != 12'd0) ? int'(count) : 1;
		rx_q.push_back(32'h0);
		if (kind == 2) begin
			flags[FLAG_DEVCFG] = 1'b1;
			cmd = {5'b0, dev, flags, 10'b0, value};
			rx_q.push_back(cmd);
			cfg_dev_q.push_back(dev);
			cfg_val_q.push_back(value);
			exp_q.push_back(32'h0);
		end else begin
			flags[FLAG_WRITE]   = (kind == 1);
			flags[FLAG_COUNTED] = counted;
			cmd = {5'b0, dev, flags, count};
			rx_q.push_back(cmd);
			rx_q.push_back({2'b00, addr});
			for (i = 0; i < n; i++) begin
				a = addr + ADDR_W'(4 * i);
				if (kind == 1) begin
					d = lcg_next() ^ (lcg_next() << 16);
					wdata.push_back(d);
					rx_q.push_back(d);
					ref_mem[a] = d;
				end else begin
					exp_q.push_back(ref_read(a));
				end
			end
			if (kind == 1) begin
				exp_q.push_back(32'h0);
			end
		end
		wait_idle("command completion");
		assert (cfg_dev_q.size() == 0) else report_mismatch("config request missing");
		// write data must have landed at consecutive word addresses
		for (i = 0; i < wdata.size(); i++) begin
			a = addr + ADDR_W'(4 * i);
			assert (mem.exists(a) && mem[a] == wdata[i]) else
				report_mismatch($sformatf("memory at %h does not hold %h", a, wdata[i]));
		end
	endtask

	// clock
	initial begin
		clock_i = 1'b0;
		forever #4 clock_i = ~clock_i;
	end

	// host fifo and bus memory models
	// --------------------------------------------------
	always @(posedge clock_i) begin
		#1;
		// flow control as the DUT saw it at this edge
		assert (!(rx_read_o && rx_empty_i)) else report_mismatch("receive read while empty");
		assert (!(tx_write_o && tx_full_i)) else report_mismatch("transmit write while full");
		assert (!(req_o && cfg_dev_q.size() == 0 && !ready_i)) else
			report_mismatch("bus request while not ready");
		// clear follows the cycle in which done was seen
		assert (clear_o == done_i) else report_mismatch("clear pulse does not follow done");
		if (rx_read_o && rx_q.size() > 0) begin
			void'(rx_q.pop_front());
		end
		rx_empty_i = (rx_q.size() == 0);
		rx_data_i  = (rx_q.size() == 0) ? 32'h0 : rx_q[0];
		tx_full_i  = stress ? (lcg_next() % 4 == 0) : 1'b0;
		ready_i    = stress ? (lcg_next() % 4 != 0) : 1'b1;
		done_i     = 1'b0;
		if (done_wait > 0) begin
			done_wait--;
			if (done_wait == 0) begin
				done_i = 1'b1;
				if (pend_rw) begin
					data_i = 32'h0;
				end else begin
					data_i = mem.exists(pend_addr) ? mem[pend_addr] : unwritten_value(pend_addr);
				end
			end
		end
		if (req_o) begin
			assert (!err_mode) else report_mismatch("bus request in error state");
			if (cfg_dev_q.size() > 0) begin
				assert (reqdev_o == cfg_dev_q[0] && data_o == {30'b0, cfg_val_q[0]}) else
					report_mismatch($sformatf("config request dev %0d data %h", reqdev_o, data_o));
				void'(cfg_dev_q.pop_front());
				void'(cfg_val_q.pop_front());
			end else begin
				assert (done_wait == 0) else report_mismatch("request while one is in flight");
				if (rw_o) begin
					mem[add_o] = data_o;
				end
				pend_rw   = rw_o;
				pend_addr = add_o;
				done_wait = int'(lcg_next() % 8) + 1;
			end
		end
	end

	// compare transmit words with the expected stream
	always @(posedge clock_i) begin
		#1;
		if (resetn_i && tx_write_o) begin
			assert (exp_q.size() > 0) else
				report_mismatch($sformatf("unexpected transmit word %h", tx_data_o));
			assert (tx_data_o == exp_q[0]) else
				report_mismatch($sformatf("transmit %h, expected %h", tx_data_o, exp_q[0]));
			void'(exp_q.pop_front());
		end
	end

	// stimulus
	// --------------------------------------------------
	initial begin
		int i;
		int n;
		logic [WORD_W-1:0] w;
		resetn_i   = 1'b0;
		rx_empty_i = 1'b1;
		rx_data_i  = '0;
		tx_full_i  = 1'b0;
		ready_i    = 1'b1;
		done_i     = 1'b0;
		data_i     = '0;

		// stale words to be purged silently
		for (i = 0; i < 6; i++) begin
			rx_q.push_back(32'h1111_0000 + i);
		end
		repeat (4) @(posedge clock_i);
		#1 resetn_i = 1'b1;

		for (n = 0; n < 25000 && UUT.u_host_link.phase != LINK_SYNC; n++) begin
			@(negedge clock_i);
		end
		if (UUT.u_host_link.phase != LINK_SYNC) begin
			report_stall("end of purge");
		end
		assert (rx_q.size() == 0) else report_mismatch("stale words not purged");

		// three sync echoes and a silent key
		for (i = 0; i < 3; i++) begin
			w = 32'h0BAD_0100 + 32'(i * 17);
			exp_q.push_back(w ^ SYNC_XOR);
			rx_q.push_back(w);
		end
		rx_q.push_back(SYNC_KEY);
		wait_idle("sync echoes");

		// directed commands
		run_command(1, 3'd0, 2'd0, 1'b1, 12'd5, 30'h0000_1000);
		run_command(0, 3'd0, 2'd0, 1'b1, 12'd5, 30'h0000_1000);
		run_command(0, 3'd0, 2'd0, 1'b0, 12'd0, 30'h0004_0000);
		run_command(2, 3'd5, 2'd2, 1'b0, 12'd0, 30'h0);

		// random commands under back-pressure
		stress = 1'b1;
		for (i = 0; i < 20; i++) begin
			run_command(int'(lcg_next() % 3), 3'(lcg_next()), 2'(lcg_next()),
			            1'(lcg_next()), 12'(lcg_next() % 6),
			            30'h0000_1000 + ADDR_W'((lcg_next() % 32) * 4));
		end
		stress = 1'b0;

		// nonzero preamble followed by traffic that must be ignored
		err_mode = 1'b1;
		rx_q.push_back(32'h0000_0001);
		for (i = 0; i < 20; i++) begin
			rx_q.push_back((i % 2 == 0) ? 32'h0 : 32'h0000_0003);
		end
		for (n = 0; n < 2000 && !exception_o; n++) begin
			@(negedge clock_i);
		end
		if (!exception_o) begin
			report_stall("exception after bad preamble");
		end
		repeat (200) begin
			@(negedge clock_i);
			assert (exception_o) else report_mismatch("exception dropped");
		end

		// only the bad preamble may have been taken from the host fifo
		if (exp_q.size() == 0 && cfg_dev_q.size() == 0 && rx_q.size() == 20) begin
			$display("All tests passed");
			$finish;
		end else begin
			$display("Some tests failed");
			$fatal(1, "traffic left over at end of run");
		end
	end

endmodule

// File: verilog/cmd_sequencer.sv
`timescale 1ns/1ps

module cmd_sequencer import comm_proto_pkg::*, mem_bus_pkg::*; (
	input  logic                   clock_i,
	input  logic                   resetn_i,
	input  logic                   word_valid_i,
	input  logic [WORD_W-1:0]      word_i,
	input  logic                   put_done_i,
	input  logic                   xfer_done_i,
	input  logic [DATA_W-1:0]      xfer_rdata_i,
	input  logic                   cfg_done_i,
	output logic                   get_req_o,
	output logic                   put_req_o,
	output logic [WORD_W-1:0]      put_data_o,
	output logic                   xfer_start_o,
	output logic                   xfer_rw_o,
	output logic [ADDR_W-1:0]      xfer_addr_o,
	output logic [DATA_W-1:0]      xfer_wdata_o,
	output logic                   cfg_start_o,
	output logic [DEV_W-1:0]       cfg_dev_o,
	output logic [CFG_VALUE_W-1:0] cfg_value_o,
	output logic                   exception_o
);

	logic [SEQ_W-1:0]   state;
	logic [COUNT_W-1:0] count;
	cmd_word_u          cmd;
	logic               last_word;

	assign cmd       = word_i;
	assign last_word = (count == COUNT_W'(1));

	// host link requests follow the state
	assign get_req_o = (state == SEQ_PREAMBLE) || (state == SEQ_COMMAND) ||
	                   (state == SEQ_ADDR) || (state == SEQ_WDATA);
	assign put_req_o = (state == SEQ_SEND) || (state == SEQ_ACK);

	// control
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state        <= SEQ_PREAMBLE;
			count        <= '0;
			xfer_start_o <= 1'b0;
			xfer_rw_o    <= 1'b0;
			cfg_start_o  <= 1'b0;
			exception_o  <= 1'b0;
		end else begin
			xfer_start_o <= 1'b0;
			cfg_start_o  <= 1'b0;

			case (state)
				SEQ_PREAMBLE: begin
					if (word_valid_i) begin
						if (word_i != '0) begin
							exception_o <= 1'b1;
							state       <= SEQ_ERROR;
						end else begin
							state <= SEQ_COMMAND;
						end
					end
				end
				SEQ_COMMAND: begin
					if (word_valid_i) begin
						if (cmd.xfer.flags[FLAG_DEVCFG]) begin
							cfg_start_o <= 1'b1;
							state       <= SEQ_CFG_WAIT;
						end else begin
							xfer_rw_o <= cmd.xfer.flags[FLAG_WRITE];
							// zero count means a single word
							if (cmd.xfer.flags[FLAG_COUNTED] && cmd.xfer.count != '0) begin
								count <= cmd.xfer.count;
							end else begin
								count <= COUNT_W'(1);
							end
							state <= SEQ_ADDR;
						end
					end
				end
				SEQ_CFG_WAIT: begin
					if (cfg_done_i) begin
						state <= SEQ_ACK;
					end
				end
				SEQ_ADDR: begin
					if (word_valid_i) begin
						if (xfer_rw_o) begin
							state <= SEQ_WDATA;
						end else begin
							xfer_start_o <= 1'b1;
							state        <= SEQ_XFER;
						end
					end
				end
				SEQ_WDATA: begin
					if (word_valid_i) begin
						xfer_start_o <= 1'b1;
						state        <= SEQ_XFER;
					end
				end
				SEQ_XFER: begin
					if (xfer_done_i) begin
						if (!xfer_rw_o) begin
							state <= SEQ_SEND;
						end else if (last_word) begin
							state <= SEQ_ACK;
						end else begin
							count <= count - COUNT_W'(1);
							state <= SEQ_WDATA;
						end
					end
				end
				SEQ_SEND: begin
					// reads have no acknowledge
					if (put_done_i) begin
						if (last_word) begin
							state <= SEQ_PREAMBLE;
						end else begin
							count        <= count - COUNT_W'(1);
							xfer_start_o <= 1'b1;
							state        <= SEQ_XFER;
						end
					end
				end
				SEQ_ACK: begin
					if (put_done_i) begin
						state <= SEQ_PREAMBLE;
					end
				end
				SEQ_ERROR: begin
					// sticky until reset
					exception_o <= 1'b1;
				end
				default: begin
					state <= SEQ_PREAMBLE;
				end
			endcase
		end
	end

	// payload
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		case (state)
			SEQ_COMMAND: begin
				if (word_valid_i) begin
					cfg_dev_o   <= cmd.cfg.dev;
					cfg_value_o <= cmd.cfg.value;
				end
			end
			SEQ_CFG_WAIT: begin
				if (cfg_done_i) begin
					put_data_o <= '0;
				end
			end
			SEQ_ADDR: begin
				if (word_valid_i) begin
					xfer_addr_o <= word_i[ADDR_W-1:0];
				end
			end
			SEQ_WDATA: begin
				if (word_valid_i) begin
					xfer_wdata_o <= word_i;
				end
			end
			SEQ_XFER: begin
				// a write steps here and a read steps once the word is sent
				if (xfer_done_i) begin
					if (xfer_rw_o) begin
						put_data_o  <= '0;
						xfer_addr_o <= xfer_addr_o + ADDR_STEP;
					end else begin
						put_data_o <= xfer_rdata_i;
					end
				end
			end
			SEQ_SEND: begin
				if (put_done_i) begin
					xfer_addr_o <= xfer_addr_o + ADDR_STEP;
				end
			end
			default: begin
			end
		endcase
	end

endmodule

// File: verilog/comm_controller.sv
`timescale 1ns/1ps

module comm_controller import comm_proto_pkg::*, mem_bus_pkg::*; (
	input  logic              clock_i,
	input  logic              resetn_i,
	// host fifos
	input  logic              tx_full_i,
	input  logic              rx_empty_i,
	input  logic [WORD_W-1:0] rx_data_i,
	output logic              rx_read_o,
	output logic              tx_write_o,
	output logic [WORD_W-1:0] tx_data_o,
	// memory/peripheral bus
	input  logic              ready_i,
	input  logic              done_i,
	input  logic [DATA_W-1:0] data_i,
	output logic [DEV_W-1:0]  reqdev_o,
	output logic              req_o,
	output logic              rw_o,
	output logic [ADDR_W-1:0] add_o,
	output logic [DATA_W-1:0] data_o,
	output logic              clear_o,
	output logic              exception_o
);

	// link to sequencer
	logic              get_req;
	logic              word_valid;
	logic [WORD_W-1:0] word;
	logic              put_req;
	logic [WORD_W-1:0] put_data;
	logic              put_done;

	// sequencer to bus master
	logic                   xfer_start;
	logic                   xfer_rw;
	logic [ADDR_W-1:0]      xfer_addr;
	logic [DATA_W-1:0]      xfer_wdata;
	logic                   xfer_done;
	logic [DATA_W-1:0]      xfer_rdata;
	logic                   cfg_start;
	logic [DEV_W-1:0]       cfg_dev;
	logic [CFG_VALUE_W-1:0] cfg_value;
	logic                   cfg_done;

	host_link u_host_link (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.rx_empty_i   (rx_empty_i),
		.rx_data_i    (rx_data_i),
		.tx_full_i    (tx_full_i),
		.get_req_i    (get_req),
		.put_req_i    (put_req),
		.put_data_i   (put_data),
		.rx_read_o    (rx_read_o),
		.tx_write_o   (tx_write_o),
		.tx_data_o    (tx_data_o),
		.word_valid_o (word_valid),
		.word_o       (word),
		.put_done_o   (put_done)
	);

	cmd_sequencer u_cmd_sequencer (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.word_valid_i (word_valid),
		.word_i       (word),
		.put_done_i   (put_done),
		.xfer_done_i  (xfer_done),
		.xfer_rdata_i (xfer_rdata),
		.cfg_done_i   (cfg_done),
		.get_req_o    (get_req),
		.put_req_o    (put_req),
		.put_data_o   (put_data),
		.xfer_start_o (xfer_start),
		.xfer_rw_o    (xfer_rw),
		.xfer_addr_o  (xfer_addr),
		.xfer_wdata_o (xfer_wdata),
		.cfg_start_o  (cfg_start),
		.cfg_dev_o    (cfg_dev),
		.cfg_value_o  (cfg_value),
		.exception_o  (exception_o)
	);

	mem_bus_master u_mem_bus_master (
		.clock_i      (clock_i),
		.resetn_i     (resetn_i),
		.ready_i      (ready_i),
		.done_i       (done_i),
		.data_i       (data_i),
		.xfer_start_i (xfer_start),
		.xfer_rw_i    (xfer_rw),
		.xfer_addr_i  (xfer_addr),
		.xfer_wdata_i (xfer_wdata),
		.cfg_start_i  (cfg_start),
		.cfg_dev_i    (cfg_dev),
		.cfg_value_i  (cfg_value),
		.req_o        (req_o),
		.rw_o         (rw_o),
		.reqdev_o     (reqdev_o),
		.add_o        (add_o),
		.data_o       (data_o),
		.clear_o      (clear_o),
		.xfer_done_o  (xfer_done),
		.xfer_rdata_o (xfer_rdata),
		.cfg_done_o   (cfg_done)
	);

endmodule

// File: verilog/comm_proto_pkg.sv
package comm_proto_pkg;

	localparam int WORD_W = 32;

	// purge ends after this many empty receive cycles in a row
	localparam int PURGE_CYCLES = 20000;
	localparam int PURGE_CNT_W  = $clog2(PURGE_CYCLES + 1);

	localparam logic [WORD_W-1:0] SYNC_KEY = 32'h4A78_B9F2;
	localparam logic [WORD_W-1:0] SYNC_XOR = 32'hCD00_31F7;

	// command flag bits
	localparam int FLAGS_W      = 12;
	localparam int FLAG_WRITE   = 0;
	localparam int FLAG_COUNTED = 1;
	localparam int FLAG_DEVCFG  = 2;

	localparam int COUNT_W     = 12;
	localparam int CFG_VALUE_W = 2;

	// host link phases
	localparam int             LINK_W     = 2;
	localparam logic [LINK_W-1:0] LINK_PURGE = 2'd0;
	localparam logic [LINK_W-1:0] LINK_SYNC  = 2'd1;
	localparam logic [LINK_W-1:0] LINK_READY = 2'd2;

	// command sequencer states
	localparam int               SEQ_W        = 4;
	localparam logic [SEQ_W-1:0] SEQ_PREAMBLE = 4'd0;
	localparam logic [SEQ_W-1:0] SEQ_COMMAND  = 4'd1;
	localparam logic [SEQ_W-1:0] SEQ_CFG_WAIT = 4'd2;
	localparam logic [SEQ_W-1:0] SEQ_ADDR     = 4'd3;
	localparam logic [SEQ_W-1:0] SEQ_WDATA    = 4'd4;
	localparam logic [SEQ_W-1:0] SEQ_XFER     = 4'd5;
	localparam logic [SEQ_W-1:0] SEQ_SEND     = 4'd6;
	localparam logic [SEQ_W-1:0] SEQ_ACK      = 4'd7;
	localparam logic [SEQ_W-1:0] SEQ_ERROR    = 4'd8;

	// command word, read as a transfer or as a device config
	typedef struct packed {
		logic [4:0]         rsvd;
		logic [2:0]         dev;
		logic [FLAGS_W-1:0] flags;
		logic [COUNT_W-1:0] count;
	} xfer_view_t;

	typedef struct packed {
		logic [4:0]             rsvd;
		logic [2:0]             dev;
		logic [FLAGS_W-1:0]     flags;
		logic [9:0]             unused;
		logic [CFG_VALUE_W-1:0] value;
	} cfg_view_t;

	typedef union packed {
		xfer_view_t xfer;
		cfg_view_t  cfg;
	} cmd_word_u;

endpackage

// File: verilog/host_link.sv
`timescale 1ns/1ps

module host_link import comm_proto_pkg::*; (
	input  logic              clock_i,
	input  logic              resetn_i,
	input  logic              rx_empty_i,
	input  logic [WORD_W-1:0] rx_data_i,
	input  logic              tx_full_i,
	input  logic              get_req_i,
	input  logic              put_req_i,
	input  logic [WORD_W-1:0] put_data_i,
	output logic              rx_read_o,
	output logic              tx_write_o,
	output logic [WORD_W-1:0] tx_data_o,
	output logic              word_valid_o,
	output logic [WORD_W-1:0] word_o,
	output logic              put_done_o
);

	logic [LINK_W-1:0]      phase;
	logic [PURGE_CNT_W-1:0] purge_cnt;

	logic purge_pop;
	logic sync_pop;
	logic sync_echo;
	logic get_pop;
	logic put_push;

	// pop/push conditions
	// --------------------------------------------------
	// the fifo advances on the edge where rx_read_o is high, so the word on
	// rx_data_i is stale for that one cycle and must not be popped again
	assign purge_pop = (phase == LINK_PURGE) && !rx_empty_i && !rx_read_o;
	assign sync_pop  = (phase == LINK_SYNC) && !rx_empty_i && !tx_full_i && !rx_read_o;
	assign sync_echo = sync_pop && (rx_data_i != SYNC_KEY);
	assign get_pop   = (phase == LINK_READY) && get_req_i && !rx_empty_i && !rx_read_o;
	// one write per put request on the transmit side
	assign put_push  = (phase == LINK_READY) && put_req_i && !tx_full_i && !tx_write_o;

	// phase control and strobes
	// --------------------------------------------------
	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			phase        <= LINK_PURGE;
			purge_cnt    <= PURGE_CNT_W'(PURGE_CYCLES);
			rx_read_o    <= 1'b0;
			tx_write_o   <= 1'b0;
			word_valid_o <= 1'b0;
			put_done_o   <= 1'b0;
		end else begin
			rx_read_o    <= purge_pop || sync_pop || get_pop;
			tx_write_o   <= sync_echo || put_push;
			word_valid_o <= get_pop;
			put_done_o   <= put_push;

			case (phase)
				LINK_PURGE: begin
					// any word present restarts the empty run
					if (!rx_empty_i) begin
						purge_cnt <= PURGE_CNT_W'(PURGE_CYCLES);
					end else if (purge_cnt != '0) begin
						purge_cnt <= purge_cnt - PURGE_CNT_W'(1);
					end else begin
						phase <= LINK_SYNC;
					end
				end
				LINK_SYNC: begin
					// key word is consumed silently
					if (sync_pop && !sync_echo) begin
						phase <= LINK_READY;
					end
				end
				LINK_READY: begin
					phase <= LINK_READY;
				end
				default: begin
					phase <= LINK_PURGE;
				end
			endcase
		end
	end

	// payload
	always_ff @(posedge clock_i) begin
		if (get_pop) begin
			word_o <= rx_data_i;
		end
		if (sync_echo) begin
			tx_data_o <= rx_data_i ^ SYNC_XOR;
		end else if (put_push) begin
			tx_data_o <= put_data_i;
		end
	end

endmodule

// File: verilog/mem_bus_master.sv
`timescale 1ns/1ps

module mem_bus_master import comm_proto_pkg::*, mem_bus_pkg::*; (
	input  logic                   clock_i,
	input  logic                   resetn_i,
	input  logic                   ready_i,
	input  logic                   done_i,
	input  logic [DATA_W-1:0]      data_i,
	input  logic                   xfer_start_i,
	input  logic                   xfer_rw_i,
	input  logic [ADDR_W-1:0]      xfer_addr_i,
	input  logic [DATA_W-1:0]      xfer_wdata_i,
	input  logic                   cfg_start_i,
	input  logic [DEV_W-1:0]       cfg_dev_i,
	input  logic [CFG_VALUE_W-1:0] cfg_value_i,
	output logic                   req_o,
	output logic                   rw_o,
	output logic [DEV_W-1:0]       reqdev_o,
	output logic [ADDR_W-1:0]      add_o,
	output logic [DATA_W-1:0]      data_o,
	output logic                   clear_o,
	output logic                   xfer_done_o,
	output logic [DATA_W-1:0]      xfer_rdata_o,
	output logic                   cfg_done_o
);

	logic [MBM_W-1:0] state;

	always_ff @(posedge clock_i) begin
		if (!resetn_i) begin
			state       <= MBM_IDLE;
			req_o       <= 1'b0;
			rw_o        <= 1'b0;
			reqdev_o    <= '0;
			add_o       <= '0;
			data_o      <= '0;
			clear_o     <= 1'b0;
			xfer_done_o <= 1'b0;
			cfg_done_o  <= 1'b0;
		end else begin
			// pulses and per-request fields fall back every cycle
			req_o       <= 1'b0;
			rw_o        <= 1'b0;
			reqdev_o    <= '0;
			clear_o     <= 1'b0;
			xfer_done_o <= 1'b0;
			cfg_done_o  <= 1'b0;

			case (state)
				MBM_IDLE: begin
					if (xfer_start_i) begin
						state <= MBM_WAIT_READY;
					end else if (cfg_start_i) begin
						// config is fire and forget, no ready or done
						req_o      <= 1'b1;
						reqdev_o   <= cfg_dev_i;
						data_o     <= {{(DATA_W-CFG_VALUE_W){1'b0}}, cfg_value_i};
						cfg_done_o <= 1'b1;
					end
				end
				MBM_WAIT_READY: begin
					if (ready_i) begin
						req_o  <= 1'b1;
						rw_o   <= xfer_rw_i;
						add_o  <= xfer_addr_i;
						data_o <= xfer_wdata_i;
						state  <= MBM_WAIT_DONE;
					end
				end
				MBM_WAIT_DONE: begin
					if (done_i) begin
						clear_o     <= 1'b1;
						xfer_done_o <= 1'b1;
						state       <= MBM_IDLE;
					end
				end
				default: begin
					state <= MBM_IDLE;
				end
			endcase
		end
	end

	// read data captured with done
	always_ff @(posedge clock_i) begin
		if (state == MBM_WAIT_DONE && done_i) begin
			xfer_rdata_o <= data_i;
		end
	end

endmodule

// File: verilog/mem_bus_pkg.sv
package mem_bus_pkg;

	// byte addressed bus
	localparam int ADDR_W = 30;
	localparam int DATA_W = 32;
	localparam int DEV_W  = 3;

	// consecutive words are one word apart in bytes
	localparam logic [ADDR_W-1:0] ADDR_STEP = 30'd4;

	// bus master states
	localparam int               MBM_W          = 2;
	localparam logic [MBM_W-1:0] MBM_IDLE       = 2'd0;
	localparam logic [MBM_W-1:0] MBM_WAIT_READY = 2'd1;
	localparam logic [MBM_W-1:0] MBM_WAIT_DONE  = 2'd2;

endpackage

// File: vlog.f
verilog/comm_proto_pkg.sv
verilog/mem_bus_pkg.sv
verilog/host_link.sv
verilog/mem_bus_master.sv
verilog/cmd_sequencer.sv
verilog/comm_controller.sv
testbench/tb_comm_controller.sv
